//--- logic/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // queue geometry
    localparam int IQ_IDX_W = 3;
    localparam int IQ_DEPTH = 1 << IQ_IDX_W;

    // register and rob id sizes
    localparam int PREG_W   = 6;
    localparam int ROB_LOG  = 5;
    localparam int ROB_ID_W = ROB_LOG + 1;

    // payload field widths
    localparam int OP_W     = 8;
    localparam int IMM_W    = 16;

    localparam int WB_PORTS = 2;

    typedef logic [PREG_W-1:0]   preg_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [IQ_DEPTH-1:0] iq_vec_t;

    // what an entry carries to the execute stage
    typedef struct packed {
        preg_t            prs1;
        preg_t            prs2;
        preg_t            prd;
        rob_id_t          robid;
        logic [OP_W-1:0]  op;
        logic [IMM_W-1:0] imm;
    } iq_payload_t;

    // top bit of a rob id flips on every pass around the rob, so a
    // differing wrap bit inverts the plain magnitude compare
    function automatic logic rob_is_younger(rob_id_t a, rob_id_t b);
        logic wrap_diff;
        logic low_after;
        wrap_diff = a[ROB_LOG] ^ b[ROB_LOG];
        low_after = b[ROB_LOG-1:0] < a[ROB_LOG-1:0];
        return wrap_diff ^ low_after;
    endfunction

endpackage

`default_nettype wire

//--- logic/iq_bcast_if.sv
`timescale 1ns/100ps
`default_nettype none

interface iq_bcast_if;

    // writeback wakeup, one slot per port
    logic           wb_valid [iq_pkg::WB_PORTS];
    iq_pkg::preg_t  wb_prd   [iq_pkg::WB_PORTS];

    // branch flush, kills everything younger than flush_robid
    logic           flush_valid;
    iq_pkg::rob_id_t flush_robid;

    modport src (
        output wb_valid,
        output wb_prd,
        output flush_valid,
        output flush_robid
    );

    modport dst (
        input wb_valid,
        input wb_prd,
        input flush_valid,
        input flush_robid
    );

endinterface

`default_nettype wire

//--- logic/iq_entry.sv
`timescale 1ns/100ps
`default_nettype none

module iq_entry (
    input  logic                clock,
    input  logic                rst,
    iq_bcast_if.dst             bcast,
    input  logic                wr_en,
    input  iq_pkg::iq_payload_t enq_payload,
    input  logic                enq_src1_is_reg,
    input  logic                enq_src2_is_reg,
    input  logic                enq_src1_ready,
    input  logic                enq_src2_ready,
    input  logic                clear,
    output logic                valid,
    output logic                ready,
    output iq_pkg::iq_payload_t payload
);

    logic src1_rdy;
    logic src2_rdy;
    logic wake_enq1;
    logic wake_enq2;
    logic wake_src1;
    logic wake_src2;
    logic flush_hit;

    // match both sources against every writeback port, for the held
    // payload and for the one arriving this cycle
    always_comb begin
        wake_enq1 = 1'b0;
        wake_enq2 = 1'b0;
        wake_src1 = 1'b0;
        wake_src2 = 1'b0;
        for (int p = 0; p < iq_pkg::WB_PORTS; p++) begin
            if (bcast.wb_valid[p]) begin
                wake_enq1 = wake_enq1 | (bcast.wb_prd[p] == enq_payload.prs1);
                wake_enq2 = wake_enq2 | (bcast.wb_prd[p] == enq_payload.prs2);
                wake_src1 = wake_src1 | (bcast.wb_prd[p] == payload.prs1);
                wake_src2 = wake_src2 | (bcast.wb_prd[p] == payload.prs2);
            end
        end
    end

    assign flush_hit = bcast.flush_valid & valid &
                       iq_pkg::rob_is_younger(payload.robid, bcast.flush_robid);

    always_ff @(posedge clock) begin
        if (rst) begin
            valid    <= 1'b0;
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (wr_en) begin
            // a non-register source never waits
            valid    <= 1'b1;
            src1_rdy <= ~enq_src1_is_reg | enq_src1_ready | wake_enq1;
            src2_rdy <= ~enq_src2_is_reg | enq_src2_ready | wake_enq2;
        end else begin
            if (clear || flush_hit) begin
                valid <= 1'b0;
            end
            src1_rdy <= src1_rdy | wake_src1;
            src2_rdy <= src2_rdy | wake_src2;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            payload <= enq_payload;
        end
    end

    assign ready = valid & src1_rdy & src2_rdy;

    // the scheduler only writes free slots and only issues live ones
    assert property (@(posedge clock) disable iff (rst) wr_en |-> !valid);
    assert property (@(posedge clock) disable iff (rst) clear |-> valid);

endmodule

`default_nettype wire

//--- logic/iq_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module iq_scheduler (
    input  logic                clock,
    input  logic                rst,
    input  logic                enq_valid,
    input  iq_pkg::iq_vec_t     entry_valid,
    input  iq_pkg::iq_vec_t     entry_ready,
    input  iq_pkg::iq_payload_t entry_payload [iq_pkg::IQ_DEPTH],
    input  logic                issue_ready,
    output logic                can_alloc,
    output iq_pkg::iq_vec_t     wr_en,
    output iq_pkg::iq_vec_t     clear,
    output logic                issue_valid,
    output iq_pkg::iq_payload_t issue_payload
);

    iq_pkg::iq_vec_t free_oh;
    iq_pkg::iq_vec_t age_grant;
    iq_pkg::iq_vec_t grant;
    iq_pkg::iq_vec_t held_oh;
    // row i has bit j set when entry j is older than entry i
    iq_pkg::iq_vec_t age [iq_pkg::IQ_DEPTH];
    logic            enq_fire;
    logic            issue_fire;
    logic            locked;
    logic            held_live;

    // lowest-numbered free slot, scanned top down so the last hit wins
    always_comb begin
        free_oh = '0;
        for (int i = iq_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_oh    = '0;
                free_oh[i] = 1'b1;
            end
        end
    end

    assign can_alloc = ~&entry_valid;
    assign enq_fire  = enq_valid & can_alloc;
    assign wr_en     = enq_fire ? free_oh : '0;

    // new entry is younger than everything valid now
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else if (enq_fire) begin
            for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
                if (free_oh[i]) begin
                    age[i] <= entry_valid;
                end else begin
                    age[i] <= age[i] & ~free_oh;
                end
            end
        end
    end

    // oldest ready: no other ready entry is older
    always_comb begin
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            age_grant[i] = entry_ready[i] & ~|(age[i] & entry_ready);
        end
    end

    // a stalled grant is kept, otherwise a late wakeup of an older
    // entry would swap the payload under the consumer
    assign held_live = locked & |(held_oh & entry_ready);
    assign grant     = held_live ? held_oh : age_grant;

    always_ff @(posedge clock) begin
        if (rst) begin
            locked <= 1'b0;
        end else begin
            locked <= issue_valid & ~issue_ready;
        end
    end

    always_ff @(posedge clock) begin
        held_oh <= grant;
    end

    assign issue_valid = |grant;
    assign issue_fire  = issue_valid & issue_ready;
    assign clear       = issue_fire ? grant : '0;

    // one-hot read of the granted slot
    always_comb begin
        issue_payload = '0;
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            if (grant[i]) begin
                issue_payload = iq_pkg::iq_payload_t'(issue_payload | entry_payload[i]);
            end
        end
    end

    assert property (@(posedge clock) disable iff (rst) $onehot0(grant));

    // payload holds across a stall unless the held entry was flushed
    assert property (@(posedge clock) disable iff (rst)
        issue_valid && !issue_ready |=>
            !(|(held_oh & entry_valid)) || (issue_payload == $past(issue_payload)));

endmodule

`default_nettype wire

//--- logic/int_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module int_issue_queue (
    input  logic                          clock,
    input  logic                          rst,
    output logic                          can_alloc,
    input  logic                          enq_valid,
    input  iq_pkg::preg_t                 enq_prs1,
    input  iq_pkg::preg_t                 enq_prs2,
    input  iq_pkg::preg_t                 enq_prd,
    input  iq_pkg::rob_id_t               enq_robid,
    input  logic [iq_pkg::OP_W-1:0]       enq_op,
    input  logic [iq_pkg::IMM_W-1:0]      enq_imm,
    input  logic                          enq_src1_is_reg,
    input  logic                          enq_src2_is_reg,
    input  logic                          enq_src1_ready,
    input  logic                          enq_src2_ready,
    output logic                          issue_valid,
    input  logic                          issue_ready,
    output iq_pkg::preg_t                 issue_prs1,
    output iq_pkg::preg_t                 issue_prs2,
    output iq_pkg::preg_t                 issue_prd,
    output iq_pkg::rob_id_t               issue_robid,
    output logic [iq_pkg::OP_W-1:0]       issue_op,
    output logic [iq_pkg::IMM_W-1:0]      issue_imm,
    input  logic                          wb0_valid,
    input  iq_pkg::preg_t                 wb0_prd,
    input  logic                          wb1_valid,
    input  iq_pkg::preg_t                 wb1_prd,
    input  logic                          flush_valid,
    input  iq_pkg::rob_id_t               flush_robid
);

    iq_pkg::iq_payload_t enq_payload;
    iq_pkg::iq_payload_t issue_payload;
    iq_pkg::iq_payload_t entry_payload [iq_pkg::IQ_DEPTH];
    iq_pkg::iq_vec_t     entry_valid;
    iq_pkg::iq_vec_t     entry_ready;
    iq_pkg::iq_vec_t     wr_en;
    iq_pkg::iq_vec_t     clear;

    iq_bcast_if bcast ();

    // broadcast seen by every slot
    assign bcast.wb_valid[0] = wb0_valid;
    assign bcast.wb_prd[0]   = wb0_prd;
    assign bcast.wb_valid[1] = wb1_valid;
    assign bcast.wb_prd[1]   = wb1_prd;
    assign bcast.flush_valid = flush_valid;
    assign bcast.flush_robid = flush_robid;

    assign enq_payload = '{prs1: enq_prs1, prs2: enq_prs2, prd: enq_prd,
                           robid: enq_robid, op: enq_op, imm: enq_imm};

    genvar i;
    generate
        for (i = 0; i < iq_pkg::IQ_DEPTH; i = i + 1) begin : g_entry
            iq_entry u_iq_entry (
                .clock           (clock),
                .rst             (rst),
                .bcast           (bcast),
                .wr_en           (wr_en[i]),
                .enq_payload     (enq_payload),
                .enq_src1_is_reg (enq_src1_is_reg),
                .enq_src2_is_reg (enq_src2_is_reg),
                .enq_src1_ready  (enq_src1_ready),
                .enq_src2_ready  (enq_src2_ready),
                .clear           (clear[i]),
                .valid           (entry_valid[i]),
                .ready           (entry_ready[i]),
                .payload         (entry_payload[i])
            );
        end
    endgenerate

    iq_scheduler u_iq_scheduler (
        .clock         (clock),
        .rst           (rst),
        .enq_valid     (enq_valid),
        .entry_valid   (entry_valid),
        .entry_ready   (entry_ready),
        .entry_payload (entry_payload),
        .issue_ready   (issue_ready),
        .can_alloc     (can_alloc),
        .wr_en         (wr_en),
        .clear         (clear),
        .issue_valid   (issue_valid),
        .issue_payload (issue_payload)
    );

    assign issue_prs1  = issue_payload.prs1;
    assign issue_prs2  = issue_payload.prs2;
    assign issue_prd   = issue_payload.prd;
    assign issue_robid = issue_payload.robid;
    assign issue_op    = issue_payload.op;
    assign issue_imm   = issue_payload.imm;

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic rst
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset covers the first 16 rising edges and drops between edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- test/tb_int_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_int_issue_queue;

    logic                     clock;
    logic                     rst;
    logic                     enq_valid;
    iq_pkg::iq_payload_t      enq_pl;
    // src1_is_reg, src2_is_reg, src1_ready, src2_ready
    logic [3:0]               enq_flags;
    logic                     issue_ready;
    logic                     wb0_valid;
    iq_pkg::preg_t            wb0_prd;
    logic                     wb1_valid;
    iq_pkg::preg_t            wb1_prd;
    logic                     flush_valid;
    iq_pkg::rob_id_t          flush_robid;
    logic                     can_alloc;
    logic                     issue_valid;
    wire iq_pkg::iq_payload_t issue_pl;

    integer      seed = 32'h9125;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    // numeric fields of the command being run
    logic [31:0] f [12];
    // last payload enqueued under each rob id
    iq_pkg::iq_payload_t sent [1 << iq_pkg::ROB_ID_W];

    tb_clock u_tb_clock (.clock(clock), .rst(rst));

    int_issue_queue int_issue_queue_inst (
        .clock (clock), .rst (rst), .can_alloc (can_alloc), .enq_valid (enq_valid),
        .enq_prs1 (enq_pl.prs1), .enq_prs2 (enq_pl.prs2), .enq_prd (enq_pl.prd),
        .enq_robid (enq_pl.robid), .enq_op (enq_pl.op), .enq_imm (enq_pl.imm),
        .enq_src1_is_reg (enq_flags[3]), .enq_src2_is_reg (enq_flags[2]),
        .enq_src1_ready (enq_flags[1]), .enq_src2_ready (enq_flags[0]),
        .issue_valid (issue_valid), .issue_ready (issue_ready),
        .issue_prs1 (issue_pl.prs1), .issue_prs2 (issue_pl.prs2), .issue_prd (issue_pl.prd),
        .issue_robid (issue_pl.robid), .issue_op (issue_pl.op), .issue_imm (issue_pl.imm),
        .wb0_valid (wb0_valid), .wb0_prd (wb0_prd), .wb1_valid (wb1_valid), .wb1_prd (wb1_prd),
        .flush_valid (flush_valid), .flush_robid (flush_robid)
    );

    // watchdog is armed once the data file length is known
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic enqueue(input logic with_wb);
        while (!can_alloc) @(negedge clock);
        enq_valid    = 1'b1;
        enq_pl.prs1  = f[0][iq_pkg::PREG_W-1:0];
        enq_pl.prs2  = f[1][iq_pkg::PREG_W-1:0];
        enq_pl.prd   = f[2][iq_pkg::PREG_W-1:0];
        enq_pl.robid = f[3][iq_pkg::ROB_ID_W-1:0];
        enq_pl.op    = f[4][iq_pkg::OP_W-1:0];
        enq_pl.imm   = f[5][iq_pkg::IMM_W-1:0];
        enq_flags    = {f[6][0], f[7][0], f[8][0], f[9][0]};
        sent[enq_pl.robid] = enq_pl;
        // writeback on both ports in the enqueue cycle
        if (with_wb) begin
            wb0_valid = 1'b1;
            wb0_prd   = f[10][iq_pkg::PREG_W-1:0];
            wb1_valid = 1'b1;
            wb1_prd   = f[11][iq_pkg::PREG_W-1:0];
        end
        @(negedge clock);
        enq_valid = 1'b0;
        wb0_valid = 1'b0;
        wb1_valid = 1'b0;
    endtask

    task automatic writeback();
        wb0_valid = f[0][0];
        wb0_prd   = f[1][iq_pkg::PREG_W-1:0];
        wb1_valid = f[2][0];
        wb1_prd   = f[3][iq_pkg::PREG_W-1:0];
        @(negedge clock);
        wb0_valid = 1'b0;
        wb1_valid = 1'b0;
    endtask

    task automatic flush_younger();
        flush_valid = 1'b1;
        flush_robid = f[0][iq_pkg::ROB_ID_W-1:0];
        @(negedge clock);
        flush_valid = 1'b0;
    endtask

    task automatic expect_issue();
        int                  hold;
        iq_pkg::iq_payload_t seen;
        while (!issue_valid) @(negedge clock);
        check_value("issue_prd", f[0][iq_pkg::PREG_W-1:0], issue_pl.prd);
        check_value("issue_robid", f[1][iq_pkg::ROB_ID_W-1:0], issue_pl.robid);
        check_value("issue_op", f[2][iq_pkg::OP_W-1:0], issue_pl.op);
        check_value("issue_imm", f[3][iq_pkg::IMM_W-1:0], issue_pl.imm);
        check_value("issue_prs1", sent[f[1][iq_pkg::ROB_ID_W-1:0]].prs1, issue_pl.prs1);
        check_value("issue_prs2", sent[f[1][iq_pkg::ROB_ID_W-1:0]].prs2, issue_pl.prs2);
        // consumer stalls for 1 to 4 cycles
        if (f[4][0]) begin
            hold = 1 + int'($unsigned($random(seed)) % 4);
            seen = issue_pl;
            repeat (hold) begin
                @(negedge clock);
                check_value("issue_valid", 1'b1, issue_valid);
                check_value("issue_payload", seen, issue_pl);
            end
        end
        issue_ready = 1'b1;
        @(negedge clock);
        issue_ready = 1'b0;
    endtask

    task automatic close_test(input string name);
        // anything still offered here was duplicated or never expected
        check_value("issue_valid", 1'b0, issue_valid);
        if (test_errors == 0) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int    fd;
        int    n;
        int    line_count;
        string cmd;
        string text;
        string name;
        enq_valid   = 1'b0;
        enq_pl      = '0;
        enq_flags   = '0;
        issue_ready = 1'b0;
        wb0_valid   = 1'b0;
        wb0_prd     = '0;
        wb1_valid   = 1'b0;
        wb1_prd     = '0;
        flush_valid = 1'b0;
        flush_robid = '0;
        line_count  = 0;
        fd = $fopen("test/int_iq_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/int_iq_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                line_count++;
            end
            $fclose(fd);
            fd = $fopen("test/int_iq_testdata.txt", "r");
        end
        cycle_limit = 40 * line_count + 16;
        @(negedge rst);
        @(negedge clock);
        check_value("can_alloc", 1'b1, can_alloc);
        check_value("issue_valid", 1'b0, issue_valid);
        while (fd != 0) begin
            if ($fscanf(fd, "%s", cmd) != 1) break;
            if (cmd == "enq" || cmd == "enqwb") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (cmd == "enqwb") n = $fscanf(fd, "%h %h", f[10], f[11]);
                enqueue(cmd == "enqwb");
            end else if (cmd == "wb") begin
                n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                writeback();
            end else if (cmd == "flush") begin
                n = $fscanf(fd, "%h", f[0]);
                flush_younger();
            end else if (cmd == "idle") begin
                n = $fscanf(fd, "%d", f[0]);
                repeat (f[0]) @(negedge clock);
            end else if (cmd == "exp") begin
                n = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                expect_issue();
            end else if (cmd == "alloc") begin
                n = $fscanf(fd, "%h %h", f[0], f[1]);
                check_value("can_alloc", f[0][0], can_alloc);
                check_value("issue_valid", f[1][0], issue_valid);
            end else if (cmd == "end") begin
                n = $fscanf(fd, "%s", name);
                close_test(name);
            end else if (cmd.substr(0, 0) == "#") begin
                n = $fgets(text, fd);
            end else begin
                $display("unknown command %s in the test data", cmd);
                errors++;
            end
        end
        if (fd != 0) $fclose(fd);
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_passed > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/int_iq_testdata.txt
# enq prs1 prs2 prd robid op imm s1_is_reg s2_is_reg s1_ready s2_ready, enqwb adds wb0_prd wb1_prd
# wb v0 prd0 v1 prd1 | flush robid | idle n | exp prd robid op imm stall | alloc can_alloc issue_valid
enq 10 00 20 00 01 1000 1 0 0 0
enq 11 00 21 01 02 1001 1 0 0 0
enq 12 00 22 02 03 1002 1 0 0 0
enq 13 00 23 03 04 1003 1 0 0 0
enq 14 00 24 04 05 1004 1 0 0 0
enq 15 00 25 05 06 1005 1 0 0 0
enq 16 00 26 06 07 1006 1 0 0 0
enq 17 00 27 07 08 1007 1 0 0 0
idle 3  alloc 0 0
wb 1 13 0 00  exp 23 03 04 1003 0  alloc 1 0
wb 1 10 1 11  wb 1 12 1 14  wb 1 15 1 16  wb 1 17 0 00
exp 20 00 01 1000 0  exp 21 01 02 1001 0  exp 22 02 03 1002 0  exp 24 04 05 1004 0
exp 25 05 06 1005 0  exp 26 06 07 1006 0  exp 27 07 08 1007 0  end full_queue
enq 30 31 28 08 21 abcd 1 1 0 0  idle 2  alloc 1 0
wb 1 30 0 00  idle 1  alloc 1 0  wb 0 00 1 31  exp 28 08 21 abcd 0  end wb_ports
enq 05 00 30 10 31 0001 1 0 0 0  enq 06 00 31 11 32 0002 1 0 0 0
enq 05 00 32 12 33 0003 1 0 0 0  enq 05 00 33 13 34 0004 1 0 0 0
wb 1 06 0 00  exp 31 11 32 0002 0  enq 05 00 34 14 35 0005 1 0 0 0  wb 0 00 1 05
exp 30 10 31 0001 0  exp 32 12 33 0003 0  exp 33 13 34 0004 0  exp 34 14 35 0005 0
end age_order
enq 01 02 35 18 41 aaaa 0 0 0 0  enq 03 04 36 19 42 bbbb 1 1 1 1
enq 05 06 37 1a 43 cccc 0 1 0 1
exp 35 18 41 aaaa 1  exp 36 19 42 bbbb 1  exp 37 1a 43 cccc 1  end back_pressure
enq 09 00 38 1e 51 0100 1 0 0 0  enq 09 00 39 1f 52 0101 1 0 0 0
enq 09 00 3a 20 53 0102 1 0 0 0  enq 09 00 3b 21 54 0103 1 0 0 0
flush 1f  wb 1 09 0 00  exp 38 1e 51 0100 0  exp 39 1f 52 0101 0  alloc 1 0
enq 0a 00 3c 3f 55 0104 1 0 0 0  enq 0a 00 3d 00 56 0105 1 0 0 0
enq 0a 00 3e 01 57 0106 1 0 0 0  enq 0a 00 3f 02 58 0107 1 0 0 0
flush 01  wb 1 0a 0 00  exp 3c 3f 55 0104 0  exp 3d 00 56 0105 0  exp 3e 01 57 0106 0
end flush
enqwb 0d 00 01 2f 61 1111 1 0 0 0 01 02  alloc 1 0
enqwb 0b 0c 02 30 62 2222 1 1 0 0 0b 0c  exp 02 30 62 2222 0
wb 1 0d 0 00  exp 01 2f 61 1111 0
enqwb 0e 00 03 31 63 3333 1 0 0 0 0e 00  exp 03 31 63 3333 0  end same_cycle

//--- vlog.f
logic/iq_pkg.sv
logic/iq_bcast_if.sv
logic/iq_entry.sv
logic/iq_scheduler.sv
logic/int_issue_queue.sv
test/tb_clock.sv
test/tb_int_issue_queue.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module tb_int_issue_queue -f vlog.f

run: build
	@out="$$(./obj_dir/Vtb_int_issue_queue)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall --timing --top-module int_issue_queue -f vlog.f

clean:
	rm -rf obj_dir
